//--- hdl/gat_pkg.sv
// GAT attention-coefficient subsystem
// Shared widths, sizes and scaling constants, plus the fetch FSM states
`default_nettype none

package gat_pkg;

  // ================================================
  // Attention weights and WH rows
  // ================================================
  // Features per row and size of each attention half, a power of two
  localparam int NUM_FEAT   = 8;
  localparam int A_SIZE     = 2 * NUM_FEAT;
  localparam int A_IDX_W    = 4;
  localparam int DATA_W     = 8;
  localparam int WH_DATA_W  = 12;
  // Eight features then the source flag in the top bit
  localparam int WH_ROW_W   = NUM_FEAT * WH_DATA_W + 1;

  // ================================================
  // Dot-product datapath
  // ================================================
  localparam int PROD_W     = DATA_W + WH_DATA_W;
  localparam int DOT_W      = 23;
  localparam int SUM_W      = DOT_W + 1;
  // Adder-tree levels, log2 of NUM_FEAT
  localparam int NUM_STAGES = 3;
  localparam int COEF_SHIFT = 10;
  localparam int COEF_MAX   = 127;

  // ================================================
  // Storage
  // ================================================
  localparam int WH_DEPTH   = 64;
  localparam int WH_ADDR_W  = 6;
  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_CNT_W = 5;

  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_RUN,
    FETCH_DRAIN
  } fetch_state_e;

endpackage

`default_nettype wire

//--- hdl/wh_rd_if.sv
// WH row read path
// Read strobe and address from the fetch FSM to the row memory,
// returned row and its valid from the memory to the pipeline
`timescale 1ns/100ps
`default_nettype none

interface wh_rd_if;

  logic                          rd_en;
  logic [gat_pkg::WH_ADDR_W-1:0] rd_addr;
  // One cycle after rd_en
  logic                          rd_vld;
  logic [gat_pkg::WH_ROW_W-1:0]  rd_data;

  modport ctrl (output rd_en, output rd_addr);
  modport mem  (input rd_en, input rd_addr, output rd_vld, output rd_data);
  modport pipe (input rd_vld, input rd_data);

endinterface

`default_nettype wire

//--- hdl/wh_row_mem.sv
// WH row memory
// 64 rows of eight signed features and a source flag, filled by the host.
// Registered read port with one cycle of latency.
`timescale 1ns/100ps
`default_nettype none

module wh_row_mem (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire                            wr_i,
  input  wire [gat_pkg::WH_ADDR_W-1:0]   wr_addr_i,
  input  wire [gat_pkg::WH_ROW_W-1:0]    wr_data_i,
  wh_rd_if.mem                           rd
);

  logic [gat_pkg::WH_ROW_W-1:0] mem_q [gat_pkg::WH_DEPTH];

  // Host write port
  always_ff @(posedge clk) begin
    if (wr_i) begin
      mem_q[wr_addr_i] <= wr_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rd.rd_en) begin
      rd.rd_data <= mem_q[rd.rd_addr];
    end
  end

  // Valid follows the strobe by one cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd.rd_vld <= 1'b0;
    end else begin
      rd.rd_vld <= rd.rd_en;
    end
  end

endmodule

`default_nettype wire

//--- hdl/attn_weight_regs.sv
// Attention weight register file
// Holds the 16 signed weights, entries 0-7 the source half and 8-15 the
// neighbour half. Writes are locked out while a batch runs.
`timescale 1ns/100ps
`default_nettype none

module attn_weight_regs (
  input  wire                                            clk,
  input  wire                                            rst_n,
  input  wire                                            wr_i,
  input  wire  [gat_pkg::A_IDX_W-1:0]                    idx_i,
  input  wire  [gat_pkg::DATA_W-1:0]                     data_i,
  input  wire                                            busy_i,
  output logic [gat_pkg::NUM_FEAT-1:0][gat_pkg::DATA_W-1:0] a_src_o,
  output logic [gat_pkg::NUM_FEAT-1:0][gat_pkg::DATA_W-1:0] a_nbr_o
);

  logic [gat_pkg::A_SIZE-1:0][gat_pkg::DATA_W-1:0] a_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_q <= '0;
    end else if (wr_i && !busy_i) begin
      a_q[idx_i] <= data_i;
    end
  end

  assign a_src_o = a_q[gat_pkg::NUM_FEAT-1:0];
  assign a_nbr_o = a_q[gat_pkg::A_SIZE-1:gat_pkg::NUM_FEAT];

  // Host should not touch the weights during a batch
  a_wr_while_busy: assert property (@(posedge clk) disable iff (!rst_n) busy_i |-> !wr_i)
    else $warning("attention weight write dropped while busy");

endmodule

`default_nettype wire

//--- hdl/wh_fetch_ctrl.sv
// WH fetch controller
// Walks a range of rows, issuing one read per cycle while a credit is
// free. Rows in flight are counted against the free FIFO slots, so the
// FIFO cannot overflow and the pipeline never stalls.
`timescale 1ns/100ps
`default_nettype none

module wh_fetch_ctrl (
  input  wire                             clk,
  input  wire                             rst_n,
  input  wire                             start_i,
  input  wire  [gat_pkg::WH_ADDR_W-1:0]   base_addr_i,
  input  wire  [gat_pkg::WH_ADDR_W:0]     num_rows_i,
  input  wire  [gat_pkg::FIFO_CNT_W-1:0]  fifo_free_i,
  input  wire                             coef_wr_i,
  output logic                            busy_o,
  wh_rd_if.ctrl                           rd
);

  gat_pkg::fetch_state_e state_q, state_d;

  logic [gat_pkg::WH_ADDR_W-1:0]  addr_q;
  logic [gat_pkg::WH_ADDR_W:0]    rows_left_q;
  logic [gat_pkg::FIFO_CNT_W-1:0] in_flight_q;

  // Issue only while a slot is left for every row already in flight
  assign rd.rd_en   = (state_q == gat_pkg::FETCH_RUN) && (rows_left_q != '0) &&
                      (in_flight_q < fifo_free_i);
  assign rd.rd_addr = addr_q;
  assign busy_o     = (state_q != gat_pkg::FETCH_IDLE);

  // ================================================
  // FSM
  // ================================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      gat_pkg::FETCH_IDLE: begin
        if (start_i) state_d = gat_pkg::FETCH_RUN;
      end
      gat_pkg::FETCH_RUN: begin
        if (rows_left_q == '0 || (rd.rd_en && rows_left_q == 1)) begin
          state_d = gat_pkg::FETCH_DRAIN;
        end
      end
      gat_pkg::FETCH_DRAIN: begin
        // Wait for the last coefficient to land in the FIFO
        if (in_flight_q == '0) state_d = gat_pkg::FETCH_IDLE;
      end
      default: state_d = gat_pkg::FETCH_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= gat_pkg::FETCH_IDLE;
      addr_q      <= '0;
      rows_left_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == gat_pkg::FETCH_IDLE && start_i) begin
        addr_q      <= base_addr_i;
        rows_left_q <= num_rows_i;
      end else if (rd.rd_en) begin
        addr_q      <= addr_q + 1'b1;
        rows_left_q <= rows_left_q - 1'b1;
      end
    end
  end

  // ================================================
  // Credit counter
  // ================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_flight_q <= '0;
    end else begin
      case ({rd.rd_en, coef_wr_i})
        2'b10:   in_flight_q <= in_flight_q + 1'b1;
        2'b01:   in_flight_q <= in_flight_q - 1'b1;
        default: in_flight_q <= in_flight_q;
      endcase
    end
  end

  in_flight_max: assert property (@(posedge clk) disable iff (!rst_n)
    in_flight_q <= gat_pkg::FIFO_CNT_W'(gat_pkg::FIFO_DEPTH));

  // A coefficient can only come back for a row that was issued
  in_flight_under: assert property (@(posedge clk) disable iff (!rst_n)
    coef_wr_i |-> in_flight_q != '0);

endmodule

`default_nettype wire

//--- hdl/dmvm_coef_pipe.sv
// Attention coefficient pipeline
// Source and neighbour dot products through a product stage and a
// registered adder tree. A flagged row reloads the source latch, then
// latched source plus neighbour goes through ReLU, shift and saturation.
// Five cycles from row valid to FIFO write, one row per cycle.
`timescale 1ns/100ps
`default_nettype none

module dmvm_coef_pipe (
  input  wire                                             clk,
  input  wire                                             rst_n,
  input  wire                                             start_i,
  input  wire  [gat_pkg::NUM_FEAT-1:0][gat_pkg::DATA_W-1:0] a_src_i,
  input  wire  [gat_pkg::NUM_FEAT-1:0][gat_pkg::DATA_W-1:0] a_nbr_i,
  output logic                                            coef_wr_o,
  output logic [gat_pkg::DATA_W-1:0]                      coef_o,
  wh_rd_if.pipe                                           rd
);

  // Half 0 is the source side, half 1 the neighbour side
  logic        [gat_pkg::NUM_FEAT-1:0][gat_pkg::DATA_W-1:0] a_w [2];
  logic signed [gat_pkg::WH_DATA_W-1:0] feat [gat_pkg::NUM_FEAT];
  logic signed [gat_pkg::PROD_W-1:0]    prod [2][gat_pkg::NUM_FEAT];
  // Level 0 holds products, level NUM_STAGES the finished dot product
  logic signed [gat_pkg::DOT_W-1:0]
    tree_q [2][gat_pkg::NUM_STAGES+1][gat_pkg::NUM_FEAT];

  logic [gat_pkg::NUM_STAGES:0] vld_sr;
  logic [gat_pkg::NUM_STAGES:0] flag_sr;

  logic signed [gat_pkg::DOT_W-1:0] src_lat_q;
  logic signed [gat_pkg::DOT_W-1:0] src_dot;
  logic signed [gat_pkg::SUM_W-1:0] sum;
  logic signed [gat_pkg::SUM_W-1:0] sum_shr;
  logic        [gat_pkg::DATA_W-1:0] coef_d;

  assign a_w[0] = a_src_i;
  assign a_w[1] = a_nbr_i;

  for (genvar k = 0; k < gat_pkg::NUM_FEAT; k++) begin : g_feat
    assign feat[k] = $signed(rd.rd_data[k*gat_pkg::WH_DATA_W +: gat_pkg::WH_DATA_W]);
  end

  // ================================================
  // Products and adder tree
  // ================================================
  for (genvar h = 0; h < 2; h++) begin : g_half
    for (genvar k = 0; k < gat_pkg::NUM_FEAT; k++) begin : g_prod
      assign prod[h][k] = $signed(a_w[h][k]) * feat[k];

      always_ff @(posedge clk) begin
        tree_q[h][0][k] <= gat_pkg::DOT_W'(prod[h][k]);
      end
    end

    for (genvar l = 1; l <= gat_pkg::NUM_STAGES; l++) begin : g_lvl
      for (genvar k = 0; k < (gat_pkg::NUM_FEAT >> l); k++) begin : g_add
        always_ff @(posedge clk) begin
          tree_q[h][l][k] <= tree_q[h][l-1][2*k] + tree_q[h][l-1][2*k+1];
        end
      end
    end
  end

  // Valid and source flag ride alongside the tree
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_sr  <= '0;
      flag_sr <= '0;
    end else begin
      vld_sr  <= {vld_sr[gat_pkg::NUM_STAGES-1:0], rd.rd_vld};
      flag_sr <= {flag_sr[gat_pkg::NUM_STAGES-1:0],
                  rd.rd_vld & rd.rd_data[gat_pkg::WH_ROW_W-1]};
    end
  end

  // ================================================
  // Source latch, ReLU and saturation
  // ================================================
  // The flagged row already uses its own source term
  assign src_dot = flag_sr[gat_pkg::NUM_STAGES] ? tree_q[0][gat_pkg::NUM_STAGES][0]
                                                : src_lat_q;
  assign sum     = gat_pkg::SUM_W'(src_dot) +
                   gat_pkg::SUM_W'(tree_q[1][gat_pkg::NUM_STAGES][0]);
  assign sum_shr = sum >>> gat_pkg::COEF_SHIFT;

  always_comb begin
    if (sum < 0) begin
      coef_d = '0;
    end else if (sum_shr > gat_pkg::COEF_MAX) begin
      coef_d = gat_pkg::DATA_W'(gat_pkg::COEF_MAX);
    end else begin
      coef_d = sum_shr[gat_pkg::DATA_W-1:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      src_lat_q <= '0;
    end else if (start_i) begin
      src_lat_q <= '0;
    end else if (flag_sr[gat_pkg::NUM_STAGES]) begin
      src_lat_q <= tree_q[0][gat_pkg::NUM_STAGES][0];
    end
  end

  // Output register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      coef_wr_o <= 1'b0;
    end else begin
      coef_wr_o <= vld_sr[gat_pkg::NUM_STAGES];
    end
  end

  always_ff @(posedge clk) begin
    coef_o <= coef_d;
  end

  // Stale tree contents must not leak out as a write after reset
  wr_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !coef_wr_o);

endmodule

`default_nettype wire

//--- hdl/coef_fifo.sv
// Coefficient FIFO
// 16-entry circular buffer with first-word fall-through. Reports its
// free slots so the fetch FSM can hold back reads.
`timescale 1ns/100ps
`default_nettype none

module coef_fifo (
  input  wire                             clk,
  input  wire                             rst_n,
  input  wire                             wr_i,
  input  wire  [gat_pkg::DATA_W-1:0]      din_i,
  input  wire                             rd_i,
  output logic [gat_pkg::DATA_W-1:0]      dout_o,
  output logic                            empty_o,
  output logic [gat_pkg::FIFO_CNT_W-1:0]  free_o
);

  logic [gat_pkg::DATA_W-1:0]     mem_q [gat_pkg::FIFO_DEPTH];
  logic [gat_pkg::FIFO_CNT_W-2:0] wr_ptr_q;
  logic [gat_pkg::FIFO_CNT_W-2:0] rd_ptr_q;
  logic [gat_pkg::FIFO_CNT_W-1:0] count_q;
  logic                           pop;

  // Pop on empty is dropped
  assign pop     = rd_i && (count_q != '0);
  assign dout_o  = mem_q[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign free_o  = gat_pkg::FIFO_CNT_W'(gat_pkg::FIFO_DEPTH) - count_q;

  always_ff @(posedge clk) begin
    if (wr_i) begin
      mem_q[wr_ptr_q] <= din_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q <= count_q + gat_pkg::FIFO_CNT_W'(wr_i) - gat_pkg::FIFO_CNT_W'(pop);
    end
  end

  // Credit counting upstream should make this impossible
  no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    wr_i |-> count_q != gat_pkg::FIFO_CNT_W'(gat_pkg::FIFO_DEPTH));

endmodule

`default_nettype wire

//--- hdl/gat_coef_top.sv
// GAT attention-coefficient top level
// Weight registers, WH row memory, fetch FSM, coefficient pipeline and
// output FIFO. The host loads weights and rows, pulses start and drains
// coefficients from the FIFO.
`timescale 1ns/100ps
`default_nettype none

module gat_coef_top (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire                            a_wr_i,
  input  wire  [gat_pkg::A_IDX_W-1:0]    a_idx_i,
  input  wire  [gat_pkg::DATA_W-1:0]     a_data_i,
  input  wire                            wh_wr_i,
  input  wire  [gat_pkg::WH_ADDR_W-1:0]  wh_addr_i,
  input  wire  [gat_pkg::WH_ROW_W-1:0]   wh_data_i,
  input  wire                            start_i,
  input  wire  [gat_pkg::WH_ADDR_W-1:0]  base_addr_i,
  input  wire  [gat_pkg::WH_ADDR_W:0]    num_rows_i,
  output logic                           busy_o,
  input  wire                            coef_rd_i,
  output logic [gat_pkg::DATA_W-1:0]     coef_o,
  output logic                           coef_empty_o
);

  logic [gat_pkg::NUM_FEAT-1:0][gat_pkg::DATA_W-1:0] a_src;
  logic [gat_pkg::NUM_FEAT-1:0][gat_pkg::DATA_W-1:0] a_nbr;
  logic                           coef_wr;
  logic [gat_pkg::DATA_W-1:0]     coef_din;
  logic [gat_pkg::FIFO_CNT_W-1:0] fifo_free;
  logic                           start_ok;

  // Start while busy does not reach the source latch
  assign start_ok = start_i && !busy_o;

  wh_rd_if rd_bus ();

  wh_row_mem u_wh_mem (
    .clk, .rst_n,
    .wr_i(wh_wr_i), .wr_addr_i(wh_addr_i), .wr_data_i(wh_data_i),
    .rd(rd_bus.mem)
  );

  attn_weight_regs u_a_regs (
    .clk, .rst_n,
    .wr_i(a_wr_i), .idx_i(a_idx_i), .data_i(a_data_i), .busy_i(busy_o),
    .a_src_o(a_src), .a_nbr_o(a_nbr)
  );

  wh_fetch_ctrl u_fetch (
    .clk, .rst_n,
    .start_i, .base_addr_i, .num_rows_i,
    .fifo_free_i(fifo_free), .coef_wr_i(coef_wr), .busy_o,
    .rd(rd_bus.ctrl)
  );

  dmvm_coef_pipe u_pipe (
    .clk, .rst_n,
    .start_i(start_ok), .a_src_i(a_src), .a_nbr_i(a_nbr),
    .coef_wr_o(coef_wr), .coef_o(coef_din),
    .rd(rd_bus.pipe)
  );

  coef_fifo u_fifo (
    .clk, .rst_n,
    .wr_i(coef_wr), .din_i(coef_din), .rd_i(coef_rd_i),
    .dout_o(coef_o), .empty_o(coef_empty_o), .free_o(fifo_free)
  );

endmodule

`default_nettype wire

//--- dv/tb_clk_gen.sv
// Testbench clock and reset
// 8 ns clock, active-low reset held for the first 16 cycles
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (16) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

//--- dv/gat_coef_tb.sv
// GAT coefficient subsystem testbench
// Directed tests against a behavioural model of the dot products,
// source latch, ReLU, shift and saturation
`timescale 1ns/100ps
`default_nettype none

module gat_coef_tb;

  localparam int TMO = 2000;

  logic clk, rst_n, a_wr, wh_wr, start, coef_rd, busy, coef_empty;
  logic [gat_pkg::A_IDX_W-1:0]   a_idx;
  logic [gat_pkg::DATA_W-1:0]    a_data, coef;
  logic [gat_pkg::WH_ADDR_W-1:0] wh_addr, base_addr;
  logic [gat_pkg::WH_ROW_W-1:0]  wh_data;
  logic [gat_pkg::WH_ADDR_W:0]   num_rows;

  // Model state
  int m_a [gat_pkg::A_SIZE];
  logic [gat_pkg::WH_ROW_W-1:0] m_row [gat_pkg::WH_DEPTH];
  int exp_q [$];
  logic [15:0] lfsr_q = 16'd6518;
  int errors = 0;
  int checks = 0;

  tb_clk_gen u_clk (.clk_o(clk), .rst_n_o(rst_n));

  gat_coef_top dut (
    .clk, .rst_n,
    .a_wr_i(a_wr), .a_idx_i(a_idx), .a_data_i(a_data),
    .wh_wr_i(wh_wr), .wh_addr_i(wh_addr), .wh_data_i(wh_data),
    .start_i(start), .base_addr_i(base_addr), .num_rows_i(num_rows), .busy_o(busy),
    .coef_rd_i(coef_rd), .coef_o(coef), .coef_empty_o(coef_empty)
  );

  // ==================================================
  // Stimulus helpers
  // ==================================================
  // 16-bit Galois LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  task automatic check_val(input string name, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
    checks++;
    if (exp_v !== act_v) begin
      errors++;
      $display("Mismatch in %s: expected %0d, actual %0d", name, exp_v, act_v);
    end
  endtask

  task automatic write_weight(input int idx, input logic [7:0] data);
    @(posedge clk);
    a_wr   <= 1'b1;
    a_idx  <= idx[gat_pkg::A_IDX_W-1:0];
    a_data <= data;
    @(posedge clk);
    a_wr   <= 1'b0;
  endtask

  // Host write that the model also sees
  task automatic set_weight(input int idx, input logic [7:0] data);
    write_weight(idx, data);
    m_a[idx] = $signed(data);
  endtask

  task automatic write_row(input int addr, input logic [gat_pkg::WH_ROW_W-1:0] row);
    @(posedge clk);
    wh_wr   <= 1'b1;
    wh_addr <= addr[gat_pkg::WH_ADDR_W-1:0];
    wh_data <= row;
    @(posedge clk);
    wh_wr   <= 1'b0;
    m_row[addr] = row;
  endtask

  // Features kept to 9 bits so sums spread across the coefficient range
  task automatic rand_row(input int addr, input logic flag);
    logic [31:0] v;
    logic [gat_pkg::WH_ROW_W-1:0] row;
    row = '0;
    for (int k = 0; k < gat_pkg::NUM_FEAT; k++) begin
      take_bits(9, v);
      row[k*gat_pkg::WH_DATA_W +: gat_pkg::WH_DATA_W] = {{3{v[8]}}, v[8:0]};
    end
    row[gat_pkg::WH_ROW_W-1] = flag;
    write_row(addr, row);
  endtask

  task automatic rand_weights();
    logic [31:0] v;
    for (int i = 0; i < gat_pkg::A_SIZE; i++) begin
      take_bits(8, v);
      set_weight(i, v[7:0]);
    end
  endtask

  // ==================================================
  // Reference model
  // ==================================================
  function automatic int model_coef(input int sum);
    int sh;
    if (sum < 0) return 0;
    sh = sum >>> gat_pkg::COEF_SHIFT;
    return (sh > gat_pkg::COEF_MAX) ? gat_pkg::COEF_MAX : sh;
  endfunction

  task automatic build_expected(input int base, input int n);
    int lat, src, nbr, f;
    logic [gat_pkg::WH_ROW_W-1:0] row;
    lat = 0;
    exp_q.delete();
    for (int r = 0; r < n; r++) begin
      row = m_row[base + r];
      src = 0;
      nbr = 0;
      for (int k = 0; k < gat_pkg::NUM_FEAT; k++) begin
        f = $signed(row[k*gat_pkg::WH_DATA_W +: gat_pkg::WH_DATA_W]);
        src += m_a[k] * f;
        nbr += m_a[gat_pkg::NUM_FEAT + k] * f;
      end
      if (row[gat_pkg::WH_ROW_W-1]) lat = src;
      exp_q.push_back(model_coef(lat + nbr));
    end
  endtask

  // ==================================================
  // Batch control
  // ==================================================
  task automatic start_batch(input int base, input int n);
    build_expected(base, n);
    @(posedge clk);
    start     <= 1'b1;
    base_addr <= base[gat_pkg::WH_ADDR_W-1:0];
    num_rows  <= n[gat_pkg::WH_ADDR_W:0];
    @(posedge clk);
    start     <= 1'b0;
  endtask

  task automatic pop_coef(output logic [31:0] val, output bit ok);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (coef_empty && cycles < TMO) begin
      @(negedge clk);
      cycles++;
    end
    ok = !coef_empty;
    val = coef;
    if (!ok) begin
      errors++;
      $display("Timeout: coef_empty_o never cleared, fetch state %s",
               dut.u_fetch.state_q.name());
    end else begin
      @(posedge clk);
      coef_rd <= 1'b1;
      @(posedge clk);
      coef_rd <= 1'b0;
    end
  endtask

  task automatic wait_idle(input string name);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (busy && cycles < TMO) begin
      @(negedge clk);
      cycles++;
    end
    if (busy) begin
      errors++;
      $display("Timeout in %s: busy_o never fell, fetch state %s", name,
               dut.u_fetch.state_q.name());
    end
  endtask

  task automatic collect_batch(input string name);
    logic [31:0] val;
    bit ok;
    while (exp_q.size() > 0) begin
      pop_coef(val, ok);
      if (!ok) break;
      check_val(name, exp_q.pop_front(), val);
    end
    wait_idle(name);
    check_val({name, " empty at end"}, 1, coef_empty);
  endtask

  task automatic report(input string name, input int err0);
    $display("%s: %s", name, (errors == err0) ? "ok" : "FAILED");
  endtask

  // ==================================================
  // Directed tests
  // ==================================================
  task automatic test_reset_state();
    int err0 = errors;
    check_val("reset_state busy", 0, busy);
    check_val("reset_state empty", 1, coef_empty);
    repeat (32) @(posedge clk);
    @(negedge clk);
    check_val("reset_state no start empty", 1, coef_empty);
    report("reset_state", err0);
  endtask

  task automatic test_single_subgraph();
    int err0 = errors;
    rand_weights();
    for (int r = 0; r < 6; r++) rand_row(r, r == 0);
    start_batch(0, 6);
    collect_batch("single_subgraph");
    report("single_subgraph", err0);
  endtask

  task automatic test_multi_subgraph();
    int err0 = errors;
    for (int r = 0; r < 12; r++) rand_row(6 + r, r == 0 || r == 4 || r == 9);
    start_batch(6, 12);
    collect_batch("multi_subgraph");
    report("multi_subgraph", err0);
  endtask

  task automatic test_relu_sat();
    int err0 = errors;
    int feat [3] = '{-10, 2000, 40};
    logic [gat_pkg::WH_ROW_W-1:0] row;
    // Row sums of 200 times the feature total land below zero, above the cap and at 62
    for (int i = 0; i < gat_pkg::A_SIZE; i++) set_weight(i, 8'd100);
    for (int r = 0; r < 3; r++) begin
      row = '0;
      for (int k = 0; k < gat_pkg::NUM_FEAT; k++) begin
        row[k*gat_pkg::WH_DATA_W +: gat_pkg::WH_DATA_W] = 12'(feat[r]);
      end
      row[gat_pkg::WH_ROW_W-1] = 1'b1;
      write_row(20 + r, row);
    end
    start_batch(20, 3);
    collect_batch("relu_sat");
    report("relu_sat", err0);
  endtask

  task automatic test_backpressure();
    int err0 = errors;
    int cycles = 0;
    rand_weights();
    for (int r = 0; r < 40; r++) rand_row(24 + r, r == 0 || r == 13 || r == 27);
    start_batch(24, 40);
    @(negedge clk);
    while (dut.u_fifo.free_o != 0 && cycles < TMO) begin
      @(negedge clk);
      cycles++;
    end
    if (dut.u_fifo.free_o != 0) begin
      errors++;
      $display("Timeout in backpressure: coefficient FIFO never filled");
    end
    // Fetching must hold off while the host is not reading
    repeat (20) @(negedge clk);
    check_val("backpressure busy", 1, busy);
    check_val("backpressure free", 0, dut.u_fifo.free_o);
    collect_batch("backpressure");
    report("backpressure", err0);
  endtask

  task automatic test_weight_lock();
    int err0 = errors;
    for (int r = 0; r < 8; r++) rand_row(r, r == 0 || r == 5);
    start_batch(0, 8);
    write_weight(3, 8'(m_a[3]) ^ 8'h55);
    collect_batch("weight_lock batch 1");
    start_batch(0, 8);
    collect_batch("weight_lock batch 2");
    report("weight_lock", err0);
  endtask

  initial begin
    int cycles;
    a_wr      = 1'b0;
    a_idx     = '0;
    a_data    = '0;
    wh_wr     = 1'b0;
    wh_addr   = '0;
    wh_data   = '0;
    start     = 1'b0;
    base_addr = '0;
    num_rows  = '0;
    coef_rd   = 1'b0;
    for (int i = 0; i < gat_pkg::A_SIZE; i++) m_a[i] = 0;
    cycles = 0;
    while (!rst_n && cycles < TMO) begin
      @(posedge clk);
      cycles++;
    end
    if (!rst_n) begin
      errors++;
      $display("Timeout: reset never released");
    end
    @(negedge clk);
    test_reset_state();
    test_single_subgraph();
    test_multi_subgraph();
    test_relu_sat();
    test_backpressure();
    test_weight_lock();
    $display("Tests: 6, checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
hdl/gat_pkg.sv
hdl/wh_rd_if.sv
hdl/wh_row_mem.sv
hdl/attn_weight_regs.sv
hdl/wh_fetch_ctrl.sv
hdl/dmvm_coef_pipe.sv
hdl/coef_fifo.sv
hdl/gat_coef_top.sv
dv/tb_clk_gen.sv
dv/gat_coef_tb.sv

//--- Bender.yml
package:
  name: gat_coef

sources:
  - hdl/gat_pkg.sv
  - hdl/wh_rd_if.sv
  - hdl/wh_row_mem.sv
  - hdl/attn_weight_regs.sv
  - hdl/wh_fetch_ctrl.sv
  - hdl/dmvm_coef_pipe.sv
  - hdl/coef_fifo.sv
  - hdl/gat_coef_top.sv
  - target: simulation
    files:
      - dv/tb_clk_gen.sv
      - dv/gat_coef_tb.sv
